// File: rtl/grad_core.sv
`timescale 1ns/100ps

module grad_core import grad_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    pix_stream_if.dst pix,
    grad_stream_if.src grad
);

    // ----------------------------------------
    // line window
    // ----------------------------------------

    // 256 entries plus tail register hold the last 257 beats
    logic [PIX_W-1:0]  line_mem [IMG_W];
    logic [COL_W-1:0]  wptr;
    logic [COL_W-1:0]  rptr;

    // pixel 255 beats back, the right neighbour of the target
    logic [PIX_W-1:0]  right_pix;
    // pixel 256 beats back, the target itself
    logic [PIX_W-1:0]  tail_pix;

    // window holds a full line
    logic              primed;
    logic              emit;

    // target pixel position
    logic [ADDR_W-1:0] tgt;
    logic [COL_W-1:0]  tgt_col;
    logic [ROW_W-1:0]  tgt_row;

    // stage 1 operands
    logic              s1_valid;
    logic              s1_last;
    logic [ADDR_W-1:0] s1_addr;
    logic [PIX_W-1:0]  s1_cur;
    logic [PIX_W-1:0]  s1_right;
    logic [PIX_W-1:0]  s1_base;
    logic              s1_zero_gx;
    logic              s1_zero_gy;

    // stage 2 inputs
    logic [DIFF_W-1:0] cur_ext;
    logic [DIFF_W-1:0] right_ext;
    logic [DIFF_W-1:0] base_ext;
    grad_word_t        next_word;

    // oldest stored entry sits just past the write pointer
    assign rptr      = wptr + 1'b1;
    assign right_pix = line_mem[rptr];

    // flush beats carry no pixel, slot is never read back as data
    always_ff @(posedge clk) begin
        if (pix.valid && !pix.flush)
            line_mem[wptr] <= pix.pixel;
    end

    // one more beat of delay behind the memory
    always_ff @(posedge clk) begin
        if (pix.valid)
            tail_pix <= right_pix;
    end

    // ----------------------------------------
    // window control
    // ----------------------------------------

    // no output until 256 beats are in
    assign emit = pix.valid && primed;

    // row major address, split into row and column
    assign tgt_col = tgt[COL_W-1:0];
    assign tgt_row = tgt[COL_W +: ROW_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            wptr   <= '0;
            primed <= 1'b0;
            tgt    <= '0;
        end else if (pix.valid) begin
            wptr <= wptr + 1'b1;
            // frame closes on the last flush beat
            if (pix.last)
                primed <= 1'b0;
            else if (wptr == COL_W'(IMG_W - 1))
                primed <= 1'b1;
            if (emit)
                tgt <= tgt + 1'b1;
        end
    end

    // ----------------------------------------
    // stage 1, capture operands
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset)
            s1_valid <= 1'b0;
        else
            s1_valid <= emit;
    end

    // right neighbour wraps into the next row at the last column
    // pixel below is a flush beat in the last row
    always_ff @(posedge clk) begin
        s1_cur     <= pix.pixel;
        s1_right   <= right_pix;
        s1_base    <= tail_pix;
        s1_addr    <= tgt;
        s1_last    <= pix.last;
        s1_zero_gx <= (tgt_col == COL_W'(IMG_W - 1));
        s1_zero_gy <= (tgt_row == ROW_W'(IMG_H - 1));
    end

    // ----------------------------------------
    // stage 2, subtract and pack
    // ----------------------------------------

    // zero extend, 10-bit wraparound gives the signed result
    assign cur_ext   = DIFF_W'(s1_cur);
    assign right_ext = DIFF_W'(s1_right);
    assign base_ext  = DIFF_W'(s1_base);

    always_comb begin
        next_word.pair.gx = s1_zero_gx ? '0 : $signed(right_ext - base_ext);
        next_word.pair.gy = s1_zero_gy ? '0 : $signed(cur_ext - base_ext);
    end

    always_ff @(posedge clk) begin
        if (reset)
            grad.valid <= 1'b0;
        else
            grad.valid <= s1_valid;
    end

    always_ff @(posedge clk) begin
        grad.addr <= s1_addr;
        grad.grad <= next_word;
        grad.last <= s1_last;
    end

endmodule

// File: rtl/grad_pkg.sv
package grad_pkg;

    // ----------------------------------------
    // frame geometry
    // ----------------------------------------

    // one square frame, row major
    localparam int IMG_W = 256;
    localparam int IMG_H = 256;
    localparam int PIX_COUNT = IMG_W * IMG_H;

    // column and row index widths
    localparam int COL_W = $clog2(IMG_W);
    localparam int ROW_W = $clog2(IMG_H);

    // ----------------------------------------
    // data widths
    // ----------------------------------------

    // byte address into either memory
    localparam int ADDR_W = 16;

    // unsigned 8-bit pixel
    localparam int PIX_W = 8;

    // signed difference, covers -255 .. 255
    localparam int DIFF_W = 10;

    // two differences side by side
    localparam int GRAD_W = 2 * DIFF_W;

    // ----------------------------------------
    // gradient word
    // ----------------------------------------

    // gx in the upper half, gy in the lower half
    typedef struct packed {
        logic signed [DIFF_W-1:0] gx;
        logic signed [DIFF_W-1:0] gy;
    } grad_pair_t;

    // raw view goes to the memory port
    // pair view is filled by the core
    typedef union packed {
        logic [GRAD_W-1:0] raw;
        grad_pair_t        pair;
    } grad_word_t;

endpackage

// File: rtl/grad_stream_if.sv
`timescale 1ns/100ps

// addressed gradient words from the core into the writer
// no ready here either
interface grad_stream_if import grad_pkg::*; ();

    // word present this cycle
    logic              valid;
    // target address in gradient memory
    logic [ADDR_W-1:0] addr;
    // packed gx / gy pair
    grad_word_t        grad;
    // word for the final address
    logic              last;

    // core side
    modport src (
        output valid,
        output addr,
        output grad,
        output last
    );

    // writer side
    modport dst (
        input valid,
        input addr,
        input grad,
        input last
    );

endinterface

// File: rtl/grad_writer.sv
`timescale 1ns/100ps

module grad_writer import grad_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    grad_stream_if.dst        grad,
    output logic              grad_wr,
    output logic [ADDR_W-1:0] grad_addr,
    output logic [GRAD_W-1:0] grad_do,
    output logic              done
);

    // write of the final word is on the port this cycle
    logic last_wr;

    // ----------------------------------------
    // memory port
    // ----------------------------------------

    // strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
            last_wr <= 1'b0;
        end else begin
            grad_wr <= grad.valid;
            last_wr <= grad.valid && grad.last;
        end
    end

    // address and data follow the strobe
    // memory sees only the raw view
    always_ff @(posedge clk) begin
        grad_addr <= grad.addr;
        grad_do   <= grad.grad.raw;
    end

    // ----------------------------------------
    // completion
    // ----------------------------------------

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset)
            done <= 1'b0;
        else if (last_wr)
            done <= 1'b1;
    end

endmodule

// File: rtl/image_gradient.sv
`timescale 1ns/100ps

module image_gradient import grad_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    output logic              img_rd,
    output logic [ADDR_W-1:0] img_addr,
    input  logic [PIX_W-1:0]  img_di,
    output logic              grad_wr,
    output logic [ADDR_W-1:0] grad_addr,
    output logic [GRAD_W-1:0] grad_do,
    output logic              done
);

    // ----------------------------------------
    // internal streams
    // ----------------------------------------

    // fetcher to core
    pix_stream_if  pix_s ();
    // core to writer
    grad_stream_if grad_s ();

    // ----------------------------------------
    // pipeline
    // ----------------------------------------

    // image reads, one pixel per clock, then one line of flush
    img_fetch u_fetch (
        .clk      (clk),
        .reset    (reset),
        .img_rd   (img_rd),
        .img_addr (img_addr),
        .img_di   (img_di),
        .pix      (pix_s)
    );

    // line window and subtractors
    grad_core u_core (
        .clk   (clk),
        .reset (reset),
        .pix   (pix_s),
        .grad  (grad_s)
    );

    // gradient memory writes and done
    grad_writer u_writer (
        .clk       (clk),
        .reset     (reset),
        .grad      (grad_s),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

endmodule

// File: rtl/img_fetch.sv
`timescale 1ns/100ps

module img_fetch import grad_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    output logic              img_rd,
    output logic [ADDR_W-1:0] img_addr,
    input  logic [PIX_W-1:0]  img_di,
    pix_stream_if.src         pix
);

    // read side
    logic [ADDR_W-1:0] rd_addr;
    logic              rd_done;

    // data return side, one cycle behind the read
    logic              data_vld;
    logic              data_last;

    // flush tail
    logic              flushing;
    logic [COL_W-1:0]  flush_cnt;

    // ----------------------------------------
    // read sequencer
    // ----------------------------------------

    // starts on its own after reset, one pass only
    always_ff @(posedge clk) begin
        if (reset) begin
            img_rd  <= 1'b0;
            rd_addr <= '0;
            rd_done <= 1'b0;
        end else if (img_rd) begin
            // stop after the last pixel
            if (rd_addr == ADDR_W'(PIX_COUNT - 1)) begin
                img_rd  <= 1'b0;
                rd_done <= 1'b1;
            end else begin
                rd_addr <= rd_addr + 1'b1;
            end
        end else if (!rd_done) begin
            img_rd <= 1'b1;
        end
    end

    assign img_addr = rd_addr;

    // ----------------------------------------
    // returned data and flush
    // ----------------------------------------

    // memory answers one cycle after the address
    always_ff @(posedge clk) begin
        if (reset) begin
            data_vld  <= 1'b0;
            data_last <= 1'b0;
        end else begin
            data_vld  <= img_rd;
            data_last <= img_rd && (rd_addr == ADDR_W'(PIX_COUNT - 1));
        end
    end

    // one line of flush beats pushes the last row through the window
    always_ff @(posedge clk) begin
        if (reset) begin
            flushing  <= 1'b0;
            flush_cnt <= '0;
        end else if (data_last) begin
            flushing  <= 1'b1;
            flush_cnt <= '0;
        end else if (flushing) begin
            flush_cnt <= flush_cnt + 1'b1;
            if (flush_cnt == COL_W'(IMG_W - 1))
                flushing <= 1'b0;
        end
    end

    // data and flush beats never overlap
    assign pix.valid = data_vld | flushing;
    assign pix.pixel = img_di;
    assign pix.flush = flushing;
    assign pix.last  = flushing && (flush_cnt == COL_W'(IMG_W - 1));

endmodule

// File: rtl/pix_stream_if.sv
`timescale 1ns/100ps

// pixel beats from the fetcher into the core
// no ready, every valid beat is consumed
interface pix_stream_if import grad_pkg::*; ();

    // beat present this cycle
    logic             valid;
    // pixel data, meaningless on flush beats
    logic [PIX_W-1:0] pixel;
    // window advance only, no pixel
    logic             flush;
    // final beat of the frame
    logic             last;

    // fetcher side
    modport src (
        output valid,
        output pixel,
        output flush,
        output last
    );

    // core side
    modport dst (
        input valid,
        input pixel,
        input flush,
        input last
    );

endinterface

// File: tb/image_gradient_assertions.sv
`timescale 1ns/100ps

module image_gradient_assertions import grad_pkg::*; (
    input logic              clk,
    input logic              reset,
    input logic              img_rd,
    input logic              grad_wr,
    input logic [ADDR_W-1:0] grad_addr,
    input logic              done
);

    // failures so far, read back from the testbench
    int fail_count = 0;

    // all strobes quiet one cycle after reset
    a_reset_quiet: assert property (@(posedge clk) reset |=> (!img_rd && !grad_wr && !done))
        else begin
            fail_count++;
            $error("img_rd, grad_wr or done high in the cycle after reset");
        end

    // done is sticky until reset
    a_done_sticky: assert property (@(posedge clk) (done && !reset) |=> done)
        else begin
            fail_count++;
            $error("done fell without reset");
        end

    // back to back writes step the address by one
    a_addr_step: assert property (@(posedge clk)
        (grad_wr && $past(grad_wr)) |-> grad_addr == ADDR_W'($past(grad_addr) + 1))
        else begin
            fail_count++;
            $error("grad_addr did not increase by one between consecutive writes");
        end

endmodule

bind image_gradient image_gradient_assertions u_assertions (
    .clk       (clk),
    .reset     (reset),
    .img_rd    (img_rd),
    .grad_wr   (grad_wr),
    .grad_addr (grad_addr),
    .done      (done)
);

// File: tb/tb_image_gradient.sv
`timescale 1ns/100ps

module tb_image_gradient import grad_pkg::*; ();

    // cycles allowed for one full frame
    localparam int TIMEOUT = 140000;

    logic              clk = 1'b0;
    logic              reset = 1'b1;
    logic              img_rd;
    logic [ADDR_W-1:0] img_addr;
    logic [PIX_W-1:0]  img_di = '0;
    logic              grad_wr;
    logic [ADDR_W-1:0] grad_addr;
    logic [GRAD_W-1:0] grad_do;
    logic              done;

    // external memories
    logic [PIX_W-1:0]  img_mem  [PIX_COUNT];
    logic [GRAD_W-1:0] grad_mem [PIX_COUNT];

    // monitor state cleared while reset is high
    int                wr_count;
    int                order_errs;
    int                rd_cycles;
    int                rd_runs;
    logic [ADDR_W-1:0] next_wr;
    logic [ADDR_W-1:0] first_rd;
    logic              rd_seen;
    logic              rd_prev;

    int                errors = 0;
    int                checks = 0;
    integer            seed = 22030;

    image_gradient dut (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // ----------------------------------------
    // memory models
    // ----------------------------------------

    // image memory answers one cycle after the address
    always @(posedge clk) begin
        img_di <= img_mem[img_addr];
    end

    // gradient memory plus write order and read burst tracking
    always @(posedge clk) begin
        if (reset) begin
            wr_count   = 0;
            order_errs = 0;
            rd_cycles  = 0;
            rd_runs    = 0;
            next_wr    = '0;
            rd_seen    = 1'b0;
            rd_prev    = 1'b0;
        end else begin
            if (grad_wr) begin
                // addresses expected in order with no gaps
                if (grad_addr !== next_wr)
                    order_errs++;
                grad_mem[grad_addr] = grad_do;
                next_wr = grad_addr + 1'b1;
                wr_count++;
            end
            if (img_rd) begin
                if (!rd_seen)
                    first_rd = img_addr;
                rd_seen = 1'b1;
                rd_cycles++;
                // each rising edge of img_rd starts a new burst
                if (!rd_prev)
                    rd_runs++;
            end
            rd_prev = img_rd;
        end
    end

    // ----------------------------------------
    // reference and helpers
    // ----------------------------------------

    // forward differences with zero on the right and bottom borders
    function automatic grad_word_t ref_word(int a);
        grad_word_t w;
        int r;
        int c;
        r = a / IMG_W;
        c = a % IMG_W;
        w.raw = '0;
        if (c != IMG_W - 1)
            w.pair.gx = DIFF_W'(int'(img_mem[a + 1]) - int'(img_mem[a]));
        if (r != IMG_H - 1)
            w.pair.gy = DIFF_W'(int'(img_mem[a + IMG_W]) - int'(img_mem[a]));
        return w;
    endfunction

    task automatic fill_random();
        for (int a = 0; a < PIX_COUNT; a++)
            img_mem[a] = PIX_W'($random(seed));
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout, done did not rise within %0d cycles", TIMEOUT);
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    // one stored word against its expected value
    task automatic compare_word(int a, grad_word_t exp);
        checks++;
        if (grad_mem[a] !== exp.raw) begin
            errors++;
            $display("[ERROR] grad_do at grad_addr %h: got %h expected %h",
                     ADDR_W'(a), grad_mem[a], exp.raw);
        end
    endtask

    task automatic compare_frame();
        for (int a = 0; a < PIX_COUNT; a++)
            compare_word(a, ref_word(a));
    endtask

    // write count, order, read burst and sticky done
    task automatic check_completion();
        int cycles;
        checks += 6;
        if (wr_count != PIX_COUNT) begin
            errors++;
            $display("[ERROR] wr_count got %h expected %h", wr_count, PIX_COUNT);
        end
        if (order_errs != 0) begin
            errors++;
            $display("gradient writes arrived out of order %0d times", order_errs);
        end
        if (rd_cycles != PIX_COUNT) begin
            errors++;
            $display("[ERROR] img_rd cycles got %h expected %h", rd_cycles, PIX_COUNT);
        end
        if (rd_runs != 1) begin
            errors++;
            $display("img_rd was split into %0d bursts instead of one", rd_runs);
        end
        if (first_rd !== '0) begin
            errors++;
            $display("[ERROR] img_addr first read got %h expected %h", first_rd, 16'h0);
        end
        // done must hold and no stray writes may follow
        cycles = 0;
        while (done && cycles < 300) begin
            @(posedge clk);
            cycles++;
        end
        if (!done || wr_count != PIX_COUNT) begin
            errors++;
            $display("done fell or extra writes came after the frame completed");
        end
    endtask

    task automatic run_frame();
        apply_reset();
        wait_done();
        check_completion();
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------

    // pixel equals column so gx is 1 inside the frame
    task automatic test_ramp();
        grad_word_t w;
        for (int a = 0; a < PIX_COUNT; a++)
            img_mem[a] = PIX_W'(a % IMG_W);
        run_frame();
        for (int a = 0; a < PIX_COUNT; a++) begin
            w.raw = '0;
            if (a % IMG_W != IMG_W - 1)
                w.pair.gx = 10'sd1;
            compare_word(a, w);
        end
    endtask

    // pixel equals row so gy is 1 above the last row
    task automatic test_rows();
        grad_word_t w;
        for (int a = 0; a < PIX_COUNT; a++)
            img_mem[a] = PIX_W'(a / IMG_W);
        run_frame();
        for (int a = 0; a < PIX_COUNT; a++) begin
            w.raw = '0;
            if (a / IMG_W != IMG_H - 1)
                w.pair.gy = 10'sd1;
            compare_word(a, w);
        end
    endtask

    task automatic test_random();
        fill_random();
        run_frame();
        compare_frame();
    endtask

    // reset once after a finished frame and again partway through
    task automatic test_mid_reset();
        int cycles;
        fill_random();
        apply_reset();
        checks++;
        if (done !== 1'b0) begin
            errors++;
            $display("[ERROR] done got %h expected %h after reset", done, 1'b0);
        end
        cycles = 0;
        while (!(grad_wr && grad_addr >= 20000) && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            errors++;
            $display("frame never reached the mid point before the second reset");
        end
        // fresh image so stale window content would show
        fill_random();
        run_frame();
        compare_frame();
    endtask

    initial begin
        test_ramp();
        test_rows();
        test_random();
        test_mid_reset();
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut.u_assertions.fail_count);
        if (errors == 0 && dut.u_assertions.fail_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: verilog.f
rtl/grad_pkg.sv
rtl/pix_stream_if.sv
rtl/grad_stream_if.sv
rtl/img_fetch.sv
rtl/grad_core.sv
rtl/grad_writer.sv
rtl/image_gradient.sv
tb/image_gradient_assertions.sv
tb/tb_image_gradient.sv
